// File: common/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define DCACHE_LINES 8
`define LINE_BYTES 8
`define WORD_BITS 32

// Line address is byte address bits 31 to 3
`define LINE_TAG_BITS 29

// Outstanding line requests
`define DCACHE_MSHR_DEPTH 4

// Memory transaction tag, zero means no transaction
`define MEM_TAG_BITS 4

// Reset value of the 8-bit victim LFSR, must be non-zero
`define DCACHE_LFSR_SEED 8'hA5

`endif

// File: common/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`LINE_TAG_BITS-1:0] line_tag_t;
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // One line, indexed by byte
    typedef logic [`LINE_BYTES-1:0][7:0] mem_block_t;
    typedef logic [`LINE_BYTES-1:0] byte_en_t;

    // Load lookup, store lookup and memory read request
    typedef struct packed {
        logic                            valid;
        line_tag_t                       tag;
        logic [$clog2(`LINE_BYTES)-1:0]  offset;
    } d_addr_req_t;

    typedef struct packed {
        logic       valid;
        mem_block_t data;
    } cache_data_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_tag_t  tag;
        mem_block_t data;
    } d_cache_line_t;

    typedef struct packed {
        logic      valid;
        mem_tag_t  mem_tag;
        line_tag_t line_tag;
    } d_mshr_entry_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            addr;
        logic [`WORD_BITS-1:0]  data;
    } d_store_req_t;

    // Returned line, valid when mem_tag is non-zero
    typedef struct packed {
        mem_tag_t   mem_tag;
        mem_block_t data;
    } d_mem_resp_t;

    typedef struct packed {
        logic       valid;
        line_tag_t  tag;
        mem_block_t data;
    } d_writeback_t;

endpackage

// File: dcache/dcache_array.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_array (
    input  logic                               clock,
    input  logic                               reset,
    input  dcache_pkg::d_addr_req_t [1:0]      load_req,
    output dcache_pkg::cache_data_t [1:0]      load_resp,
    input  dcache_pkg::line_tag_t              store_tag,
    output logic                               store_hit,
    input  logic                               store_en,
    input  dcache_pkg::byte_en_t               store_byte_en,
    input  dcache_pkg::mem_block_t             store_data,
    input  dcache_pkg::d_addr_req_t            refill,
    input  dcache_pkg::mem_block_t             refill_data,
    output dcache_pkg::d_cache_line_t          victim,
    output logic                               victim_valid
);

    localparam int INDEX_BITS = $clog2(`DCACHE_LINES);
    localparam int LFSR_BITS = 8;
    localparam logic [LFSR_BITS-1:0] LFSR_TAPS = 8'hB8;

    dcache_pkg::d_cache_line_t lines [`DCACHE_LINES];

    logic [LFSR_BITS-1:0]  lfsr;
    logic [INDEX_BITS-1:0] store_idx;
    logic [INDEX_BITS-1:0] free_idx;
    logic [INDEX_BITS-1:0] victim_idx;
    logic [INDEX_BITS-1:0] alloc_idx;
    logic                  has_free;
    dcache_pkg::mem_block_t merged;
    logic                  merged_dirty;

    // Fully associative match on both load ports
    always_comb begin
        load_resp = '0;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < `DCACHE_LINES; i++) begin
                if (load_req[p].valid && lines[i].valid &&
                    lines[i].tag == load_req[p].tag) begin
                    load_resp[p].valid = 1'b1;
                    load_resp[p].data = lines[i].data;
                end
            end
        end
    end

    always_comb begin
        store_hit = 1'b0;
        store_idx = '0;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            if (lines[i].valid && lines[i].tag == store_tag) begin
                store_hit = 1'b1;
                store_idx = INDEX_BITS'(i);
            end
        end
    end

    // Scan downward so the lowest free line wins
    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = `DCACHE_LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                has_free = 1'b1;
                free_idx = INDEX_BITS'(i);
            end
        end
    end

    assign victim_idx = lfsr[INDEX_BITS-1:0];
    assign alloc_idx = has_free ? free_idx : victim_idx;

    // Eviction only happens when a refill finds no free line
    always_comb begin
        victim = '0;
        victim_valid = 1'b0;
        if (refill.valid && !has_free) begin
            victim = lines[victim_idx];
            victim_valid = lines[victim_idx].valid;
        end
    end

    // Byte merge of the store into the hit line
    always_comb begin
        merged = lines[store_idx].data;
        for (int b = 0; b < `LINE_BYTES; b++) begin
            if (store_byte_en[b]) begin
                merged[b] = store_data[b];
            end
        end
        // A silent store keeps a clean line clean
        merged_dirty = lines[store_idx].dirty || (merged != lines[store_idx].data);
    end

    // Galois LFSR, free running
    always_ff @(posedge clock) begin
        if (!reset) begin
            lfsr <= `DCACHE_LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[LFSR_BITS-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `DCACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (refill.valid) begin
            lines[alloc_idx] <= '{valid: 1'b1, dirty: 1'b0, tag: refill.tag, data: refill_data};
        end else if (store_en && store_hit) begin
            lines[store_idx].dirty <= merged_dirty;
            lines[store_idx].data <= merged;
        end
    end

endmodule

// File: dcache/dcache_mshr.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_mshr (
    input  logic                        clock,
    input  logic                        reset,
    input  dcache_pkg::line_tag_t       snoop_tag,
    output logic                        snoop_found,
    output logic                        full,
    input  dcache_pkg::d_mshr_entry_t   push,
    input  dcache_pkg::mem_tag_t        resp_tag,
    output dcache_pkg::d_addr_req_t     refill
);

    localparam int DEPTH = `DCACHE_MSHR_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    dcache_pkg::d_mshr_entry_t entries [DEPTH];

    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic                pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return PTR_BITS'(ptr + 1'b1);
    endfunction

    // Tail slot still occupied means every entry is in flight
    assign full = entries[tail].valid;

    always_comb begin
        snoop_found = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (entries[i].valid && entries[i].line_tag == snoop_tag) begin
                snoop_found = 1'b1;
            end
        end
    end

    // Memory answers in order, so only the head can match
    assign pop = (resp_tag != '0) && entries[head].valid &&
                 (resp_tag == entries[head].mem_tag);

    always_comb begin
        refill = '0;
        refill.valid = pop;
        refill.tag = entries[head].line_tag;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head <= next_ptr(head);
            end
            if (push.valid) begin
                entries[tail] <= push;
                tail <= next_ptr(tail);
            end
        end
    end

endmodule

// File: logic/dcache_miss_ctrl.sv
`timescale 1ns/1ns

module dcache_miss_ctrl (
    input  dcache_pkg::d_store_req_t        store_req,
    output logic                            store_done,
    output dcache_pkg::line_tag_t           store_tag,
    input  logic                            store_hit,
    output logic                            store_en,
    output dcache_pkg::byte_en_t            store_byte_en,
    output dcache_pkg::mem_block_t          store_data,
    input  dcache_pkg::d_addr_req_t [1:0]   load_req,
    input  dcache_pkg::cache_data_t [1:0]   load_resp,
    input  logic                            refill_active,
    input  dcache_pkg::d_cache_line_t       victim,
    input  logic                            victim_valid,
    input  logic                            mshr_found,
    input  logic                            mshr_full,
    output dcache_pkg::line_tag_t           snoop_tag,
    output dcache_pkg::d_addr_req_t         mem_req,
    input  logic                            mem_req_accepted,
    input  dcache_pkg::mem_tag_t            mem_req_tag,
    output dcache_pkg::d_mshr_entry_t       push,
    output dcache_pkg::d_writeback_t        mem_wb
);

    logic                  miss_valid;
    dcache_pkg::line_tag_t miss_tag;

    assign store_tag = store_req.addr[31:3];

    // Word store, address bit 2 picks the half of the line
    always_comb begin
        store_data = '0;
        store_byte_en = '0;
        if (store_req.addr[2]) begin
            store_data[7:4] = store_req.data;
            store_byte_en[7:4] = '1;
        end else begin
            store_data[3:0] = store_req.data;
            store_byte_en[3:0] = '1;
        end
    end

    // Refill owns the array write port this cycle, store retries
    assign store_en = store_req.valid && store_hit && !refill_active;
    assign store_done = store_en;

    // Oldest miss: store, then load port 0, then port 1
    always_comb begin
        miss_valid = 1'b0;
        miss_tag = '0;
        if (store_req.valid && !store_hit) begin
            miss_valid = 1'b1;
            miss_tag = store_tag;
        end else if (load_req[0].valid && !load_resp[0].valid) begin
            miss_valid = 1'b1;
            miss_tag = load_req[0].tag;
        end else if (load_req[1].valid && !load_resp[1].valid) begin
            miss_valid = 1'b1;
            miss_tag = load_req[1].tag;
        end
    end

    assign snoop_tag = miss_tag;

    always_comb begin
        mem_wb.valid = victim_valid && victim.dirty;
        mem_wb.tag = victim.tag;
        mem_wb.data = victim.data;
    end

    // Writeback wins the memory port, duplicates and a full table wait
    always_comb begin
        mem_req = '0;
        mem_req.valid = miss_valid && !mem_wb.valid && !mshr_found && !mshr_full;
        mem_req.tag = miss_tag;
    end

    always_comb begin
        push.valid = mem_req.valid && mem_req_accepted && (mem_req_tag != '0);
        push.mem_tag = mem_req_tag;
        push.line_tag = mem_req.tag;
    end

endmodule

// File: logic/dcache_subsystem.sv
`timescale 1ns/1ns

module dcache_subsystem (
    input  logic                            clock,
    input  logic                            reset,
    input  dcache_pkg::d_addr_req_t [1:0]   load_req,
    output dcache_pkg::cache_data_t [1:0]   load_resp,
    input  dcache_pkg::d_store_req_t        store_req,
    output logic                            store_done,
    output dcache_pkg::d_addr_req_t         mem_req,
    input  logic                            mem_req_accepted,
    input  dcache_pkg::mem_tag_t            mem_req_tag,
    input  dcache_pkg::d_mem_resp_t         mem_resp,
    output dcache_pkg::d_writeback_t        mem_wb
);

    dcache_pkg::line_tag_t     store_tag;
    logic                      store_hit;
    logic                      store_en;
    dcache_pkg::byte_en_t      store_byte_en;
    dcache_pkg::mem_block_t    store_data;
    dcache_pkg::d_addr_req_t   refill;
    dcache_pkg::d_cache_line_t victim;
    logic                      victim_valid;
    dcache_pkg::line_tag_t     snoop_tag;
    logic                      mshr_found;
    logic                      mshr_full;
    dcache_pkg::d_mshr_entry_t push;

    dcache_array i_array (
        .clock         (clock),
        .reset         (reset),
        .load_req      (load_req),
        .load_resp     (load_resp),
        .store_tag     (store_tag),
        .store_hit     (store_hit),
        .store_en      (store_en),
        .store_byte_en (store_byte_en),
        .store_data    (store_data),
        .refill        (refill),
        .refill_data   (mem_resp.data),
        .victim        (victim),
        .victim_valid  (victim_valid)
    );

    dcache_mshr i_mshr (
        .clock       (clock),
        .reset       (reset),
        .snoop_tag   (snoop_tag),
        .snoop_found (mshr_found),
        .full        (mshr_full),
        .push        (push),
        .resp_tag    (mem_resp.mem_tag),
        .refill      (refill)
    );

    dcache_miss_ctrl i_miss_ctrl (
        .store_req        (store_req),
        .store_done       (store_done),
        .store_tag        (store_tag),
        .store_hit        (store_hit),
        .store_en         (store_en),
        .store_byte_en    (store_byte_en),
        .store_data       (store_data),
        .load_req         (load_req),
        .load_resp        (load_resp),
        .refill_active    (refill.valid),
        .victim           (victim),
        .victim_valid     (victim_valid),
        .mshr_found       (mshr_found),
        .mshr_full        (mshr_full),
        .snoop_tag        (snoop_tag),
        .mem_req          (mem_req),
        .mem_req_accepted (mem_req_accepted),
        .mem_req_tag      (mem_req_tag),
        .push             (push),
        .mem_wb           (mem_wb)
    );

endmodule

// File: dv/dcache_properties.sv
`timescale 1ns/1ns

module dcache_properties (
    input logic                      clock,
    input logic                      reset,
    input dcache_pkg::d_addr_req_t   mem_req,
    input dcache_pkg::d_writeback_t  mem_wb,
    input dcache_pkg::d_store_req_t  store_req,
    input logic                      store_done
);

    // Writeback and read request share the memory port
    req_wb_exclusive: assert property (@(posedge clock) disable iff (!reset)
        !(mem_req.valid && mem_wb.valid))
        else $error("mem_req and mem_wb valid in the same cycle");

    store_done_needs_store: assert property (@(posedge clock) disable iff (!reset)
        store_done |-> store_req.valid)
        else $error("store_done raised without a valid store");

    // Line requests are always line aligned
    req_offset_zero: assert property (@(posedge clock) disable iff (!reset)
        mem_req.valid |-> (mem_req.offset == '0))
        else $error("mem_req valid with a non-zero offset");

endmodule

bind dcache_subsystem dcache_properties i_properties (
    .clock      (clock),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_wb     (mem_wb),
    .store_req  (store_req),
    .store_done (store_done)
);

// File: dv/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

    localparam int WAIT_LIMIT = 200;

    logic                          clock;
    logic                          reset;
    dcache_pkg::d_addr_req_t [1:0] load_req;
    dcache_pkg::cache_data_t [1:0] load_resp;
    dcache_pkg::d_store_req_t      store_req;
    logic                          store_done;
    dcache_pkg::d_addr_req_t       mem_req;
    logic                          mem_req_accepted;
    dcache_pkg::mem_tag_t          mem_req_tag;
    dcache_pkg::d_mem_resp_t       mem_resp;
    dcache_pkg::d_writeback_t      mem_wb;

    logic [31:0] lfsr_state;
    // Memory contents written back, and lines holding stored data
    logic [63:0] mem_lines [dcache_pkg::line_tag_t];
    logic [63:0] cached_lines [dcache_pkg::line_tag_t];
    dcache_pkg::line_tag_t req_log [$];
    dcache_pkg::line_tag_t pend_line [$];
    dcache_pkg::mem_tag_t  pend_tag [$];
    int                    wb_count;
    dcache_pkg::line_tag_t last_wb_tag;
    logic [63:0]           last_wb_data;
    string                 test_name;
    int                    test_errors;
    int                    tests_run;
    int                    tests_failed;

    dcache_subsystem i_dut (
        .clock            (clock),
        .reset            (reset),
        .load_req         (load_req),
        .load_resp        (load_resp),
        .store_req        (store_req),
        .store_done       (store_done),
        .mem_req          (mem_req),
        .mem_req_accepted (mem_req_accepted),
        .mem_req_tag      (mem_req_tag),
        .mem_resp         (mem_resp),
        .mem_wb           (mem_wb)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Initial memory image that uses every address bit in both halves
    function automatic logic [63:0] line_pattern(input dcache_pkg::line_tag_t tag);
        return {({3'b101, tag} ^ 32'h5a5a0f0f), {tag, 3'b011}};
    endfunction

    function automatic logic [63:0] memory_value(input dcache_pkg::line_tag_t tag);
        if (mem_lines.exists(tag)) begin
            return mem_lines[tag];
        end
        return line_pattern(tag);
    endfunction

    function automatic logic [63:0] expected_line(input dcache_pkg::line_tag_t tag);
        if (cached_lines.exists(tag)) begin
            return cached_lines[tag];
        end
        return memory_value(tag);
    endfunction

    // Memory model samples at the falling edge and acts just after the rising edge
    initial begin
        logic                     req_seen;
        dcache_pkg::line_tag_t    req_line;
        logic                     wb_seen;
        dcache_pkg::d_writeback_t wb;
        int                       delay;
        mem_req_tag = 4'd1;
        mem_resp = '0;
        wb_count = 0;
        delay = 0;
        forever begin
            @(negedge clock);
            req_seen = mem_req.valid && mem_req_accepted;
            req_line = mem_req.tag;
            wb_seen = mem_wb.valid;
            wb = mem_wb;
            @(posedge clock);
            #1;
            mem_resp = '0;
            if (wb_seen === 1'b1) begin
                mem_lines[wb.tag] = wb.data;
                wb_count++;
                last_wb_tag = wb.tag;
                last_wb_data = wb.data;
            end
            if (req_seen === 1'b1) begin
                req_log.push_back(req_line);
                pend_line.push_back(req_line);
                pend_tag.push_back(mem_req_tag);
                mem_req_tag = (mem_req_tag == 4'd15) ? 4'd1 : mem_req_tag + 4'd1;
            end
            if (pend_line.size() > 0) begin
                if (delay == 0) begin
                    mem_resp.mem_tag = pend_tag.pop_front();
                    mem_resp.data = memory_value(pend_line.pop_front());
                    delay = 1 + int'(take_bits(2));
                end else begin
                    delay--;
                end
            end
        end
    end

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        load_req = '0;
        store_req = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b1;
        cached_lines.delete();
    endtask

    task automatic drive_load(input int port, input dcache_pkg::line_tag_t tag);
        load_req[port].valid = 1'b1;
        load_req[port].tag = tag;
        load_req[port].offset = '0;
    endtask

    // Waits for a hit on one port and compares its line one cycle before returning
    task automatic wait_load_hit(input int port, input dcache_pkg::line_tag_t tag);
        logic hit;
        int   cycles;
        hit = 1'b0;
        cycles = 0;
        while (!hit && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            if (load_resp[port].valid === 1'b1) begin
                hit = 1'b1;
                check_value("load data", expected_line(tag), load_resp[port].data);
            end
            cycles++;
            next_cycle();
        end
        if (!hit) begin
            report_error($sformatf("load on port %0d never hit line %h", port, tag));
        end
    endtask

    task automatic fill_line(input dcache_pkg::line_tag_t tag);
        drive_load(0, tag);
        wait_load_hit(0, tag);
        load_req[0] = '0;
    endtask

    // Store stays on the port until the cache takes it
    task automatic wait_store_done();
        logic                  done;
        int                    cycles;
        dcache_pkg::line_tag_t tag;
        logic [63:0]           line;
        done = 1'b0;
        cycles = 0;
        tag = store_req.addr[31:3];
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            if (store_done === 1'b1) begin
                done = 1'b1;
                line = expected_line(tag);
                if (store_req.addr[2]) begin
                    line[63:32] = store_req.data;
                end else begin
                    line[31:0] = store_req.data;
                end
                cached_lines[tag] = line;
            end
            cycles++;
            next_cycle();
        end
        if (!done) begin
            report_error($sformatf("store to %h never completed", store_req.addr));
        end
        store_req = '0;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
        store_req.valid = 1'b1;
        store_req.addr = addr;
        store_req.data = data;
        wait_store_done();
    endtask

    task automatic test_load_miss_request();
        start_test("load_miss_request");
        drive_load(0, 29'h0000_0a10);
        @(negedge clock);
        check_value("load hit", 64'd0, 64'(load_resp[0].valid));
        check_value("writeback valid", 64'd0, 64'(mem_wb.valid));
        check_value("request valid", 64'd1, 64'(mem_req.valid));
        check_value("request tag", 64'(29'h0000_0a10), 64'(mem_req.tag));
        check_value("request offset", 64'd0, 64'(mem_req.offset));
        next_cycle();
        wait_load_hit(0, 29'h0000_0a10);
        load_req = '0;
        finish_test();
    endtask

    task automatic test_refill_both_ports();
        int start;
        int count;
        start_test("refill_both_ports");
        start = req_log.size();
        count = 0;
        drive_load(0, 29'h0000_0b20);
        next_cycle();
        // Same line on the other port while it is outstanding
        drive_load(1, 29'h0000_0b20);
        wait_load_hit(0, 29'h0000_0b20);
        @(negedge clock);
        check_value("port 1 hit", 64'd1, 64'(load_resp[1].valid));
        check_value("port 1 data", expected_line(29'h0000_0b20), load_resp[1].data);
        next_cycle();
        load_req = '0;
        for (int i = start; i < req_log.size(); i++) begin
            if (req_log[i] == 29'h0000_0b20) begin
                count++;
            end
        end
        check_value("request count", 64'd1, 64'(count));
        finish_test();
    endtask

    task automatic test_port_order();
        int start;
        start_test("port_order");
        start = req_log.size();
        drive_load(0, 29'h0000_0c30);
        drive_load(1, 29'h0000_0d40);
        @(negedge clock);
        check_value("first request valid", 64'd1, 64'(mem_req.valid));
        check_value("first request tag", 64'(29'h0000_0c30), 64'(mem_req.tag));
        next_cycle();
        wait_load_hit(0, 29'h0000_0c30);
        wait_load_hit(1, 29'h0000_0d40);
        load_req = '0;
        if (req_log.size() < start + 2) begin
            report_error("fewer than two line requests were seen");
        end else begin
            check_value("older request", 64'(29'h0000_0c30), 64'(req_log[start]));
            check_value("younger request", 64'(29'h0000_0d40), 64'(req_log[start + 1]));
        end
        finish_test();
    endtask

    task automatic test_store_miss();
        start_test("store_miss");
        store_req.valid = 1'b1;
        store_req.addr = {29'h0000_0e50, 3'b100};
        store_req.data = take_bits(32);
        @(negedge clock);
        check_value("store done on miss", 64'd0, 64'(store_done));
        check_value("request valid", 64'd1, 64'(mem_req.valid));
        check_value("request tag", 64'(29'h0000_0e50), 64'(mem_req.tag));
        next_cycle();
        wait_store_done();
        fill_line(29'h0000_0e50);
        finish_test();
    endtask

    task automatic test_clean_eviction();
        int wb_before;
        start_test("clean_eviction");
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            fill_line(29'd100 + 29'(i));
        end
        wb_before = wb_count;
        fill_line(29'd108);
        check_value("writeback count", 64'(wb_before), 64'(wb_count));
        finish_test();
    endtask

    task automatic test_dirty_eviction();
        int                    wb_before;
        dcache_pkg::line_tag_t tag;
        logic [63:0]           old_line;
        logic [31:0]           old_word;
        start_test("dirty_eviction");
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            tag = 29'd200 + 29'(i);
            old_line = memory_value(tag);
            old_word = i[0] ? old_line[63:32] : old_line[31:0];
            // Flip every bit outside the random mask so the line turns dirty
            store_word({tag, i[0], 2'b00}, ~old_word ^ (take_bits(32) & 32'h00ff00ff));
        end
        wb_before = wb_count;
        fill_line(29'd208);
        check_value("writeback count", 64'(wb_before + 1), 64'(wb_count));
        if (last_wb_tag < 29'd200 || last_wb_tag > 29'd207) begin
            report_error($sformatf("writeback carried unexpected line %h", last_wb_tag));
        end else begin
            check_value("writeback data", cached_lines[last_wb_tag], last_wb_data);
            drive_load(0, last_wb_tag);
            @(negedge clock);
            check_value("evicted line hit", 64'd0, 64'(load_resp[0].valid));
            next_cycle();
            wait_load_hit(0, last_wb_tag);
            load_req = '0;
        end
        finish_test();
    endtask

    initial begin
        lfsr_state = 32'h6d025235;
        reset = 1'b0;
        load_req = '0;
        store_req = '0;
        mem_req_accepted = 1'b1;
        tests_run = 0;
        tests_failed = 0;
        apply_reset();
        test_load_miss_request();
        test_refill_both_ports();
        test_port_order();
        test_store_miss();
        test_clean_eviction();
        test_dirty_eviction();
        repeat (4) next_cycle();
        $display("Summary: %0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/dcache_pkg.sv
dcache/dcache_array.sv
dcache/dcache_mshr.sv
logic/dcache_miss_ctrl.sv
logic/dcache_subsystem.sv
dv/dcache_properties.sv
dv/dcache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the data-cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module dcache_tb \
    --Mdir obj_dir -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi

if ! grep -q "Verification passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
